// File: all.f
hw/arm_pkg.sv
hw/control_unit.sv
hw/register_file.sv
hw/id_stage.sv
hw/exe_stage.sv
hw/wb_stage.sv
hw/arm_core.sv
dv/arm_core_assertions.sv
dv/arm_core_checker.sv
dv/arm_core_tb.sv

// File: Makefile
.PHONY: compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module arm_core_tb -f all.f -o arm_core_tb

run: compile
	./obj_dir/arm_core_tb > sim.log 2>&1; cat sim.log; \
	if grep -q "=== FAIL ===" sim.log; then exit 1; fi; \
	if ! grep -q "=== PASS ===" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: dv/arm_core_tb.sv
module arm_core_tb import arm_pkg::*; ();

	localparam int n_instr = 60;
	localparam int n_tests = 6;
	localparam int limit_cycles = 16 + n_tests * (n_instr + 12) + 50;

	typedef struct packed {
		logic wb;
		reg_idx_t dest;
		word_t value;
		logic rd;
		logic wr;
		word_t addr;
		word_t wdata;
		logic br;
		word_t target;
		flags_t flags;
	} exp_t;

	logic clk;
	logic rst;
	logic instr_valid;
	fetch_pkt_t fetch;
	word_t mem_rdata = '0;
	mem_req_t mem_req;
	logic branch_taken;
	word_t branch_target;
	flags_t status;
	logic wb_enable;
	reg_idx_t wb_dest;
	word_t wb_value;
	int unsigned cycle = 0;

	// reference state and generator state.
	word_t ref_regs [16];
	flags_t ref_flags;
	word_t ref_mem [word_t];
	word_t dut_mem [word_t];
	logic squash_next;
	word_t seed;
	word_t pc;
	word_t redirect_pc;
	logic redirect;
	int last_dest;
	int prev_dest;

	arm_core #(
		.num_regs(16)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.instr_valid(instr_valid),
		.fetch(fetch),
		.mem_req(mem_req),
		.mem_rdata(mem_rdata),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.status(status),
		.wb_enable(wb_enable),
		.wb_dest(wb_dest),
		.wb_value(wb_value)
	);

	arm_core_checker u_chk (
		.clk(clk),
		.rst(rst),
		.cycle(cycle),
		.mem_req(mem_req),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.status(status),
		.wb_enable(wb_enable),
		.wb_dest(wb_dest),
		.wb_value(wb_value)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	function automatic word_t fill_word(word_t a);
		return {a[15:0], ~a[31:16]} ^ 32'h3c5a96e1;
	endfunction

	// memory model answering in the cycle the request is visible.
	always @(posedge clk) begin
		#1;
		if (mem_req.write) begin
			dut_mem[mem_req.addr] = mem_req.wdata;
		end
		if (mem_req.read) begin
			mem_rdata = dut_mem.exists(mem_req.addr) ? dut_mem[mem_req.addr]
				: fill_word(mem_req.addr);
		end else begin
			mem_rdata = '0;
		end
	end

	function automatic word_t xorshift(word_t x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic word_t rand32();
		seed = xorshift(seed);
		return seed;
	endfunction

	function automatic word_t rotr(word_t x, int n);
		if (n == 0) begin
			return x;
		end
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic logic cond_holds(cond_t c, flags_t f);
		logic n;
		logic z;
		logic cf;
		logic v;
		logic r;
		{n, z, cf, v} = f;
		case (c[3:1])
			3'd0: r = z;
			3'd1: r = cf;
			3'd2: r = n;
			3'd3: r = v;
			3'd4: r = cf && !z;
			3'd5: r = (n == v);
			3'd6: r = !z && (n == v);
			default: r = 1'b1;
		endcase
		// odd codes are the inverse of the even one below.
		if (c[0] && c[3:1] != 3'd7) begin
			r = !r;
		end
		if (c == 4'hf) begin
			r = 1'b0;
		end
		return r;
	endfunction

	// ************************************************************************
	// reference model
	// ************************************************************************

	function automatic exp_t ref_step(logic valid, word_t ipc, word_t ins);
		exp_t e;
		word_t a;
		word_t b;
		word_t r;
		logic [32:0] wide;
		logic c_out;
		logic v_out;
		logic cin;
		logic borrow;
		int off;
		e = '0;
		e.flags = ref_flags;
		if (squash_next || !valid) begin
			squash_next = 1'b0;
			return e;
		end
		if (!cond_holds(ins[31:28], ref_flags)) begin
			return e;
		end
		a = ref_regs[ins[19:16]];
		case (ins[27:26])
			2'b10: begin
				e.br = 1'b1;
				off = $signed(ins[23:0]);
				e.target = ipc + 32'd8 + word_t'(off * 4);
				squash_next = 1'b1;
			end
			2'b01: begin
				e.addr = a + {20'h0, ins[11:0]};
				if (ins[20]) begin
					e.rd = 1'b1;
					e.wb = 1'b1;
					e.dest = ins[15:12];
					e.value = ref_mem.exists(e.addr) ? ref_mem[e.addr] : fill_word(e.addr);
					ref_regs[e.dest] = e.value;
				end else begin
					e.wr = 1'b1;
					e.wdata = ref_regs[ins[15:12]];
					ref_mem[e.addr] = e.wdata;
				end
			end
			default: begin
				b = ins[25] ? rotr({24'h0, ins[7:0]}, int'({ins[11:8], 1'b0}))
					: ref_regs[ins[3:0]];
				c_out = ref_flags[1];
				v_out = ref_flags[0];
				e.wb = 1'b1;
				e.dest = ins[15:12];
				case (ins[24:21])
					4'b1101: r = b;
					4'b1111: r = ~b;
					4'b0000, 4'b1000: r = a & b;
					4'b1100: r = a | b;
					4'b0001: r = a ^ b;
					4'b0100, 4'b0101: begin
						cin = (ins[24:21] == 4'b0101) && ref_flags[1];
						wide = {1'b0, a} + {1'b0, b} + {32'h0, cin};
						r = wide[31:0];
						c_out = wide[32];
						v_out = (a[31] == b[31]) && (r[31] != a[31]);
					end
					default: begin
						// sub, sbc and cmp. carry means no borrow.
						borrow = (ins[24:21] == 4'b0110) && !ref_flags[1];
						r = a - b - {31'h0, borrow};
						c_out = ({1'b0, a} >= {1'b0, b} + {32'h0, borrow});
						v_out = (a[31] != b[31]) && (r[31] != a[31]);
					end
				endcase
				if (ins[24:21] == 4'b1000 || ins[24:21] == 4'b1010) begin
					e.wb = 1'b0;
				end
				e.value = r;
				if (e.wb) begin
					ref_regs[e.dest] = r;
				end
				if (ins[20]) begin
					ref_flags = {r[31], r == 32'h0, c_out, v_out};
				end
				e.flags = ref_flags;
			end
		endcase
		return e;
	endfunction

	// ************************************************************************
	// instruction generator
	// ************************************************************************

	task automatic note_slot(input logic writes, input logic [3:0] rd);
		prev_dest = last_dest;
		last_dest = writes ? int'(rd) : -1;
	endtask

	// sources never match the previous slot's destination.
	function automatic logic [3:0] pick_src();
		word_t x;
		logic [3:0] r;
		x = rand32();
		r = x[3:0];
		if (x[4] && prev_dest >= 0) begin
			r = prev_dest[3:0];
		end
		while (last_dest >= 0 && r == last_dest[3:0]) begin
			r = r + 4'd1;
		end
		return r;
	endfunction

	function automatic logic [3:0] dp_op(logic [3:0] k);
		case (int'(k) % 11)
			0: return 4'b0000;
			1: return 4'b0001;
			2: return 4'b0010;
			3: return 4'b0100;
			4: return 4'b0101;
			5: return 4'b0110;
			6: return 4'b1000;
			7: return 4'b1010;
			8: return 4'b1100;
			9: return 4'b1101;
			default: return 4'b1111;
		endcase
	endfunction

	// kind 0 is alu, 1 flags, 2 cond, 3 memory, 4 branch and 5 mixed.
	task automatic gen(input int kind, output word_t ins);
		word_t x;
		int sel;
		logic [3:0] op;
		logic [3:0] rn;
		logic [3:0] rm;
		logic [3:0] rd;
		logic [3:0] cond;
		logic s;
		x = rand32();
		case (kind)
			0, 1, 2: sel = kind;
			3: sel = (x[1:0] == 2'b00) ? 0 : 3;
			4: sel = (x[1:0] == 2'b00) ? 4 : 2;
			default: sel = int'(x[4:2]) % 5;
		endcase
		rn = pick_src();
		rm = pick_src();
		x = rand32();
		rd = x[7:4];
		op = dp_op(x[19:16]);
		cond = 4'he;
		s = (sel >= 1) ? x[1] : 1'b0;
		if (sel == 2 || sel == 4) begin
			cond = x[27:24];
			if (cond == 4'hf) begin
				cond = 4'he;
			end
		end
		if (sel == 3) begin
			// few base registers so loads meet earlier stores.
			rn = {2'b00, x[9:8]};
			while (last_dest >= 0 && rn == last_dest[3:0]) begin
				rn = {2'b00, rn[1:0] + 2'b01};
			end
			if (x[15]) begin
				ins = {cond, 2'b01, 1'b0, 4'b1100, 1'b1, rn, 1'b1, x[14:12], 8'h0,
					x[19:18], 2'b00};
				note_slot(1'b1, {1'b1, x[14:12]});
			end else begin
				rd = pick_src();
				ins = {cond, 2'b01, 1'b0, 4'b1100, 1'b0, rn, rd, 8'h0, x[19:18], 2'b00};
				note_slot(1'b0, rd);
			end
		end else if (sel == 4) begin
			ins = {cond, 4'b1010, x[31:8]};
			note_slot(1'b0, 4'h0);
		end else begin
			if (op == 4'b1000 || op == 4'b1010) begin
				s = 1'b1;
			end
			ins = {cond, 2'b00, x[0], op, s, rn, rd, x[0] ? x[31:20] : {8'h0, rm}};
			note_slot(!(op == 4'b1000 || op == 4'b1010), rd);
		end
	endtask

	// ************************************************************************
	// stimulus
	// ************************************************************************

	task automatic issue(input logic valid, input word_t ins, input logic track);
		exp_t rec;
		@(posedge clk);
		#2;
		instr_valid = valid;
		fetch.pc = pc;
		fetch.instr = ins;
		if (!valid) begin
			note_slot(1'b0, 4'h0);
		end
		rec = ref_step(valid, pc, ins);
		if (track) begin
			u_chk.expect_rec(cycle + 3, rec.wb, rec.dest, rec.value, rec.rd, rec.wr,
				rec.addr, rec.wdata, rec.br, rec.target, rec.flags);
		end
		if (valid) begin
			pc = pc + 32'd4;
		end
		// fetch side follows the branch after the squashed slot.
		if (rec.br) begin
			redirect_pc = rec.target;
			redirect = 1'b1;
		end else if (redirect) begin
			pc = redirect_pc;
			redirect = 1'b0;
		end
	endtask

	task automatic run_test(input int kind, input string name);
		word_t x;
		word_t ins;
		for (int i = 0; i < n_instr; i++) begin
			x = rand32();
			if (x[2:0] == 3'd0) begin
				issue(1'b0, '0, 1'b1);
			end else begin
				gen(kind, ins);
				issue(1'b1, ins, 1'b1);
			end
		end
		while (u_chk.pending() > 0) begin
			issue(1'b0, '0, 1'b0);
		end
		u_chk.report_test(name);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		instr_valid = 1'b0;
		fetch = '0;
		seed = 32'hef831ae2;
		pc = '0;
		redirect_pc = '0;
		redirect = 1'b0;
		squash_next = 1'b0;
		ref_flags = '0;
		last_dest = -1;
		prev_dest = -1;
		for (int i = 0; i < 16; i++) begin
			ref_regs[i] = '0;
		end
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;
		run_test(0, "alu");
		run_test(1, "flags");
		run_test(2, "cond");
		run_test(3, "memory");
		run_test(4, "branch");
		run_test(5, "mixed");
		u_chk.report_totals();
		if (u_chk.total_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (limit_cycles) @(posedge clk);
		$display("timeout, tests did not finish within %0d cycles", limit_cycles);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: dv/arm_core_checker.sv
module arm_core_checker import arm_pkg::*; (
	input logic clk,
	input logic rst,
	input int unsigned cycle,
	input mem_req_t mem_req,
	input logic branch_taken,
	input word_t branch_target,
	input flags_t status,
	input logic wb_enable,
	input reg_idx_t wb_dest,
	input word_t wb_value
);

	typedef struct {
		int unsigned due;
		logic wb;
		reg_idx_t dest;
		word_t value;
		logic rd;
		logic wr;
		word_t addr;
		word_t wdata;
		logic br;
		word_t target;
		flags_t flags;
	} rec_t;

	rec_t q[$];
	int total_checks = 0;
	int total_errors = 0;
	int test_checks = 0;
	int test_errors = 0;
	int n_tests = 0;

	task automatic expect_rec(input int unsigned due, input logic wb, input reg_idx_t dest,
		input word_t value, input logic rd, input logic wr, input word_t addr,
		input word_t wdata, input logic br, input word_t target, input flags_t flags);
		rec_t r;
		r.due = due;
		r.wb = wb;
		r.dest = dest;
		r.value = value;
		r.rd = rd;
		r.wr = wr;
		r.addr = addr;
		r.wdata = wdata;
		r.br = br;
		r.target = target;
		r.flags = flags;
		q.push_back(r);
	endtask

	function automatic int pending();
		return q.size();
	endfunction

	task automatic check_val(input string name, input word_t got, input word_t exp);
		test_checks++;
		if (got !== exp) begin
			test_errors++;
			$display("** Error: %s = 0x%h, expected 0x%h at cycle %0d", name, got, exp, cycle);
		end
	endtask

	// ************************************************************************
	// compare at the fixed latency
	// ************************************************************************

	always @(negedge clk) begin : compare
		rec_t r;
		if (!rst && q.size() > 0) begin
			if (q[0].due < cycle) begin
				test_errors++;
				$display("outputs due at cycle %0d were never compared", q[0].due);
				void'(q.pop_front());
			end else if (q[0].due == cycle) begin
				r = q.pop_front();
				check_val("wb_enable", {31'h0, wb_enable}, {31'h0, r.wb});
				if (r.wb) begin
					check_val("wb_dest", {28'h0, wb_dest}, {28'h0, r.dest});
					check_val("wb_value", wb_value, r.value);
				end
				check_val("mem_req.read", {31'h0, mem_req.read}, {31'h0, r.rd});
				check_val("mem_req.write", {31'h0, mem_req.write}, {31'h0, r.wr});
				if (r.rd || r.wr) begin
					check_val("mem_req.addr", mem_req.addr, r.addr);
				end
				if (r.wr) begin
					check_val("mem_req.wdata", mem_req.wdata, r.wdata);
				end
				check_val("branch_taken", {31'h0, branch_taken}, {31'h0, r.br});
				if (r.br) begin
					check_val("branch_target", branch_target, r.target);
				end
				check_val("status", {28'h0, status}, {28'h0, r.flags});
			end
		end
	end

	task automatic report_test(input string name);
		n_tests++;
		$display("test %-8s %0d checks, %0d errors", name, test_checks, test_errors);
		total_checks += test_checks;
		total_errors += test_errors;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic report_totals();
		$display("%0d tests, %0d checks, %0d errors", n_tests, total_checks, total_errors);
	endtask

endmodule

// File: dv/arm_core_assertions.sv
module arm_core_assertions (
	input logic clk,
	input logic rst,
	input logic rd,
	input logic wr,
	input logic pulse,
	input logic en
);

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(rd && wr))
		else $error("memory read and write requested in the same cycle");

	a_branch_pulse: assert property (@(posedge clk) disable iff (rst) pulse |=> !pulse)
		else $error("branch_taken high for more than one cycle");

	a_reset_low: assert property (@(posedge clk) rst |=> !rd && !wr && !pulse && !en)
		else $error("outputs not low after reset");

endmodule

bind exe_stage arm_core_assertions u_exe_assertions (
	.clk(clk),
	.rst(rst),
	.rd(mem_req.read),
	.wr(mem_req.write),
	.pulse(branch_taken),
	.en(1'b0)
);

bind wb_stage arm_core_assertions u_wb_assertions (
	.clk(clk),
	.rst(rst),
	.rd(1'b0),
	.wr(1'b0),
	.pulse(1'b0),
	.en(wb_enable)
);

// File: hw/arm_core.sv
module arm_core import arm_pkg::*; #(
	parameter int num_regs = 16
) (
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input fetch_pkt_t fetch,
	output mem_req_t mem_req,
	input word_t mem_rdata,
	output logic branch_taken,
	output word_t branch_target,
	output flags_t status,
	output logic wb_enable,
	output reg_idx_t wb_dest,
	output word_t wb_value
);

	reg_idx_t rn_idx;
	reg_idx_t rm_idx;
	word_t rn_val;
	word_t rm_val;
	logic squash;
	id_ex_t id_ex;
	ex_wb_t ex_wb;

	id_stage u_id_stage (
		.clk(clk),
		.rst(rst),
		.instr_valid(instr_valid),
		.fetch(fetch),
		.squash(squash),
		.rn_idx(rn_idx),
		.rm_idx(rm_idx),
		.rn_val(rn_val),
		.rm_val(rm_val),
		.id_ex(id_ex)
	);

	exe_stage u_exe_stage (
		.clk(clk),
		.rst(rst),
		.id_ex(id_ex),
		.ex_wb(ex_wb),
		.mem_req(mem_req),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.squash(squash),
		.status(status)
	);

	wb_stage u_wb_stage (
		.clk(clk),
		.rst(rst),
		.ex_wb(ex_wb),
		.mem_rdata(mem_rdata),
		.wb_enable(wb_enable),
		.wb_dest(wb_dest),
		.wb_value(wb_value)
	);

	register_file #(
		.num_regs(num_regs)
	) u_register_file (
		.clk(clk),
		.rst(rst),
		.rn_idx(rn_idx),
		.rm_idx(rm_idx),
		.rn_val(rn_val),
		.rm_val(rm_val),
		.wr_en(wb_enable),
		.wr_idx(wb_dest),
		.wr_data(wb_value)
	);

endmodule

// File: hw/wb_stage.sv
module wb_stage import arm_pkg::*; (
	input logic clk,
	input logic rst,
	input ex_wb_t ex_wb,
	input word_t mem_rdata,
	output logic wb_enable,
	output reg_idx_t wb_dest,
	output word_t wb_value
);

	ex_wb_t wb_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_q.valid <= 1'b0;
		end else begin
			wb_q <= ex_wb;
		end
	end

	// load data arrives the cycle after the request.
	assign wb_enable = wb_q.valid && wb_q.wb_enable;
	assign wb_dest = wb_q.dest;
	assign wb_value = wb_q.mem_read ? mem_rdata : wb_q.result;

endmodule

// File: hw/exe_stage.sv
module exe_stage import arm_pkg::*; (
	input logic clk,
	input logic rst,
	input id_ex_t id_ex,
	output ex_wb_t ex_wb,
	output mem_req_t mem_req,
	output logic branch_taken,
	output word_t branch_target,
	output logic squash,
	output flags_t status
);

	logic fire;
	logic is_arith;
	logic carry_in;
	logic [63:0] imm_dbl;
	logic [32:0] sum;
	word_t op2;
	word_t b_in;
	word_t result;
	flags_t flags_next;

	function automatic logic cond_pass(cond_t c, flags_t f);
		logic n;
		logic z;
		logic cy;
		logic v;
		{n, z, cy, v} = f;
		case (c)
			4'h0: return z;
			4'h1: return !z;
			4'h2: return cy;
			4'h3: return !cy;
			4'h4: return n;
			4'h5: return !n;
			4'h6: return v;
			4'h7: return !v;
			4'h8: return cy && !z;
			4'h9: return !cy || z;
			4'ha: return n == v;
			4'hb: return n != v;
			4'hc: return !z && (n == v);
			4'hd: return z || (n != v);
			4'he: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	assign fire = id_ex.valid && cond_pass(id_ex.cond, status);
	assign squash = fire && id_ex.ctrl.branch_taken;

	// ************************************************************************
	// operand and alu
	// ************************************************************************

	// 8-bit immediate rotated right by twice the rotate field.
	assign imm_dbl = {24'b0, id_ex.shifter[7:0], 24'b0, id_ex.shifter[7:0]}
		>> {id_ex.shifter[11:8], 1'b0};

	always_comb begin
		if (id_ex.ctrl.mem_read || id_ex.ctrl.mem_write) begin
			op2 = {20'b0, id_ex.shifter};
		end else if (id_ex.ctrl.immediate) begin
			op2 = imm_dbl[31:0];
		end else begin
			op2 = id_ex.rm_val;
		end
	end

	assign is_arith = id_ex.ctrl.exe_cmd inside {exe_add, exe_adc, exe_sub, exe_sbc, exe_cmp};

	always_comb begin
		case (id_ex.ctrl.exe_cmd)
			exe_adc, exe_sbc: carry_in = status[1];
			exe_sub, exe_cmp: carry_in = 1'b1;
			default: carry_in = 1'b0;
		endcase
	end

	assign b_in = (id_ex.ctrl.exe_cmd inside {exe_sub, exe_sbc, exe_cmp}) ? ~op2 : op2;
	assign sum = {1'b0, id_ex.rn_val} + {1'b0, b_in} + {32'b0, carry_in};

	always_comb begin
		case (id_ex.ctrl.exe_cmd)
			exe_mov: result = op2;
			exe_mvn: result = ~op2;
			exe_and, exe_tst: result = id_ex.rn_val & op2;
			exe_orr: result = id_ex.rn_val | op2;
			exe_eor: result = id_ex.rn_val ^ op2;
			default: result = sum[31:0];
		endcase
	end

	// logic ops keep c and v.
	assign flags_next[3] = result[31];
	assign flags_next[2] = (result == '0);
	assign flags_next[1] = is_arith ? sum[32] : status[1];
	assign flags_next[0] = is_arith
		? (id_ex.rn_val[31] == b_in[31]) && (sum[31] != id_ex.rn_val[31])
		: status[0];

	always_comb begin
		ex_wb.valid = fire;
		ex_wb.wb_enable = id_ex.ctrl.wb_enable;
		ex_wb.mem_read = id_ex.ctrl.mem_read;
		ex_wb.dest = id_ex.dest;
		ex_wb.result = result;
	end

	// ************************************************************************
	// registered outputs
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			status <= '0;
		end else if (fire && id_ex.ctrl.status_write) begin
			status <= flags_next;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mem_req.read <= 1'b0;
			mem_req.write <= 1'b0;
			branch_taken <= 1'b0;
		end else begin
			mem_req.read <= fire && id_ex.ctrl.mem_read;
			mem_req.write <= fire && id_ex.ctrl.mem_write;
			mem_req.addr <= result;
			mem_req.wdata <= id_ex.rm_val;
			branch_taken <= squash;
			// pc + 8 + offset in words.
			branch_target <= id_ex.pc + 32'd8 + {{6{id_ex.offset[23]}}, id_ex.offset, 2'b00};
		end
	end

endmodule

// File: hw/id_stage.sv
module id_stage import arm_pkg::*; (
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input fetch_pkt_t fetch,
	input logic squash,
	output reg_idx_t rn_idx,
	output reg_idx_t rm_idx,
	input word_t rn_val,
	input word_t rm_val,
	output id_ex_t id_ex
);

	logic ir_valid;
	fetch_pkt_t ir;
	mode_t mode;
	opcode_t opcode;
	logic s_bit;
	logic imm_bit;
	reg_idx_t rd;
	ctrl_t ctrl;
	id_ex_t id_ex_next;

	// ************************************************************************
	// instruction register
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			ir_valid <= 1'b0;
		end else begin
			ir_valid <= instr_valid;
			ir <= fetch;
		end
	end

	assign mode = mode_t'(ir.instr[27:26]);
	assign imm_bit = ir.instr[25];
	assign opcode = opcode_t'(ir.instr[24:21]);
	assign s_bit = ir.instr[20];
	assign rd = ir.instr[15:12];

	control_unit u_control_unit (
		.mode(mode),
		.opcode(opcode),
		.s(s_bit),
		.immediate_in(imm_bit),
		.ctrl(ctrl)
	);

	// stores read their data from rd over the rm port.
	assign rn_idx = ir.instr[19:16];
	assign rm_idx = ctrl.mem_write ? rd : ir.instr[3:0];

	always_comb begin
		id_ex_next.valid = ir_valid && !squash;
		id_ex_next.pc = ir.pc;
		id_ex_next.cond = ir.instr[31:28];
		id_ex_next.ctrl = ctrl;
		id_ex_next.rn_val = rn_val;
		id_ex_next.rm_val = rm_val;
		id_ex_next.shifter = ir.instr[11:0];
		id_ex_next.offset = ir.instr[23:0];
		id_ex_next.dest = rd;
		id_ex_next.rn_idx = rn_idx;
		id_ex_next.rm_idx = rm_idx;
	end

	// ************************************************************************
	// decode to execute register
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (rst) begin
			id_ex.valid <= 1'b0;
		end else begin
			id_ex <= id_ex_next;
		end
	end

endmodule

// File: hw/register_file.sv
module register_file import arm_pkg::*; #(
	parameter int num_regs = 16
) (
	input logic clk,
	input logic rst,
	input reg_idx_t rn_idx,
	input reg_idx_t rm_idx,
	output word_t rn_val,
	output word_t rm_val,
	input logic wr_en,
	input reg_idx_t wr_idx,
	input word_t wr_data
);

	word_t regs [num_regs];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// write-through on index match.
	assign rn_val = (wr_en && wr_idx == rn_idx) ? wr_data : regs[rn_idx];
	assign rm_val = (wr_en && wr_idx == rm_idx) ? wr_data : regs[rm_idx];

endmodule

// File: hw/control_unit.sv
module control_unit import arm_pkg::*; (
	input mode_t mode,
	input opcode_t opcode,
	input logic s,
	input logic immediate_in,
	output ctrl_t ctrl
);

	always_comb begin
		ctrl.exe_cmd = exe_mov;
		ctrl.mem_read = 1'b0;
		ctrl.mem_write = 1'b0;
		ctrl.wb_enable = 1'b0;
		ctrl.branch_taken = 1'b0;
		ctrl.status_write = 1'b0;
		ctrl.immediate = immediate_in;

		case (mode)
			arith_mode: begin
				ctrl.status_write = s;
				// everything but the compares writes rd.
				ctrl.wb_enable = 1'b1;
				case (opcode)
					op_mov: ctrl.exe_cmd = exe_mov;
					op_mvn: ctrl.exe_cmd = exe_mvn;
					op_add: ctrl.exe_cmd = exe_add;
					op_adc: ctrl.exe_cmd = exe_adc;
					op_sub: ctrl.exe_cmd = exe_sub;
					op_sbc: ctrl.exe_cmd = exe_sbc;
					op_and: ctrl.exe_cmd = exe_and;
					op_orr: ctrl.exe_cmd = exe_orr;
					op_eor: ctrl.exe_cmd = exe_eor;
					op_cmp: begin
						ctrl.exe_cmd = exe_cmp;
						ctrl.wb_enable = 1'b0;
					end
					op_tst: begin
						ctrl.exe_cmd = exe_tst;
						ctrl.wb_enable = 1'b0;
					end
					default: begin
						ctrl.wb_enable = 1'b0;
						ctrl.status_write = 1'b0;
					end
				endcase
			end

			memory_mode: begin
				// address is base plus offset.
				ctrl.exe_cmd = exe_add;
				if (s) begin
					ctrl.mem_read = 1'b1;
					ctrl.wb_enable = 1'b1;
				end else begin
					ctrl.mem_write = 1'b1;
				end
			end

			branch_mode: begin
				ctrl.branch_taken = 1'b1;
			end

			default: begin
				ctrl.exe_cmd = exe_mov;
			end
		endcase
	end

endmodule

// File: hw/arm_pkg.sv
package arm_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0] reg_idx_t;
	typedef logic [3:0] cond_t;
	// n, z, c, v from the top bit down.
	typedef logic [3:0] flags_t;

	typedef enum logic [1:0] {
		arith_mode  = 2'b00,
		memory_mode = 2'b01,
		branch_mode = 2'b10
	} mode_t;

	// arm data-processing opcodes.
	typedef enum logic [3:0] {
		op_and = 4'b0000,
		op_eor = 4'b0001,
		op_sub = 4'b0010,
		op_add = 4'b0100,
		op_adc = 4'b0101,
		op_sbc = 4'b0110,
		op_tst = 4'b1000,
		op_cmp = 4'b1010,
		op_orr = 4'b1100,
		op_mov = 4'b1101,
		op_mvn = 4'b1111
	} opcode_t;

	typedef enum logic [3:0] {
		exe_mov,
		exe_mvn,
		exe_add,
		exe_adc,
		exe_sub,
		exe_sbc,
		exe_and,
		exe_orr,
		exe_eor,
		exe_cmp,
		exe_tst,
		exe_ldr,
		exe_str
	} exe_cmd_t;

	typedef struct packed {
		word_t pc;
		word_t instr;
	} fetch_pkt_t;

	typedef struct packed {
		exe_cmd_t exe_cmd;
		logic mem_read;
		logic mem_write;
		logic wb_enable;
		logic branch_taken;
		logic status_write;
		logic immediate;
	} ctrl_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		cond_t cond;
		ctrl_t ctrl;
		word_t rn_val;
		word_t rm_val;
		logic [11:0] shifter;
		logic [23:0] offset;
		reg_idx_t dest;
		reg_idx_t rn_idx;
		reg_idx_t rm_idx;
	} id_ex_t;

	typedef struct packed {
		logic valid;
		logic wb_enable;
		logic mem_read;
		reg_idx_t dest;
		word_t result;
	} ex_wb_t;

	typedef struct packed {
		logic read;
		logic write;
		word_t addr;
		word_t wdata;
	} mem_req_t;

endpackage
